//--- verilog/isaPkg.sv
package isaPkg;

	localparam int dataWidth = 32;
	localparam int wordAddrWidth = 30; // byte address without bits 1:0
	localparam int regIdxWidth = 5;
	localparam int opWidth = 6;
	localparam int fnWidth = 6;
	localparam int immWidth = 16;

	localparam int opLsb = 26;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	localparam int fnLsb = 0;
	localparam int immLsb = 0;

	typedef logic [regIdxWidth-1:0] regIdx;

	localparam logic [opWidth-1:0] opRtype = 6'd0;
	localparam logic [opWidth-1:0] opBeq = 6'd4;
	localparam logic [opWidth-1:0] opAddi = 6'd8;
	localparam logic [opWidth-1:0] opSlti = 6'd10;
	localparam logic [opWidth-1:0] opAndi = 6'd12;
	localparam logic [opWidth-1:0] opOri = 6'd13;
	localparam logic [opWidth-1:0] opXori = 6'd14;
	localparam logic [opWidth-1:0] opLw = 6'd35;
	localparam logic [opWidth-1:0] opSw = 6'd43;

	localparam logic [fnWidth-1:0] fnAdd = 6'd32;
	localparam logic [fnWidth-1:0] fnSub = 6'd34;
	localparam logic [fnWidth-1:0] fnAnd = 6'd36;
	localparam logic [fnWidth-1:0] fnOr = 6'd37;
	localparam logic [fnWidth-1:0] fnXor = 6'd38;
	localparam logic [fnWidth-1:0] fnNor = 6'd39;
	localparam logic [fnWidth-1:0] fnSlt = 6'd42;

	typedef enum logic [2:0] {
		aluAdd, // zero, so a bubble decodes as add
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt
	} aluOp;

	localparam logic [dataWidth-1:0] nopWord = '0;

endpackage

//--- verilog/pipePkg.sv
package pipePkg;

	import isaPkg::*;

	// decode to execute
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic useImm;
		aluOp op;
		regIdx rs;
		regIdx rt; // zero when rt is not a source
		regIdx rd; // zero unless the result is written
		logic [dataWidth-1:0] rsVal;
		logic [dataWidth-1:0] rtVal;
		logic [dataWidth-1:0] imm;
	} idExPayload;

	// execute to memory
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		regIdx rd;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] storeData;
	} exMemPayload;

	// memory to writeback
	typedef struct packed {
		logic regWrite;
		regIdx rd;
		logic [dataWidth-1:0] wbData;
	} memWbPayload;

endpackage

//--- verilog/pipeReg.sv
`timescale 1ns/10ps

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic freeze,
	input logic bubble,
	input payloadT d,
	output payloadT q
);

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (!freeze) begin
			if (bubble)
				q <= '0; // all-zero payload does nothing
			else
				q <= d;
		end
	end

endmodule

//--- verilog/fetchStage.sv
`timescale 1ns/10ps

module fetchStage import isaPkg::*; #(
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic freeze,
	input logic hazard,
	input logic branchTaken,
	input logic [dataWidth-1:0] branchTarget,
	output logic icacheRen,
	output logic [wordAddrWidth-1:0] icacheAddr, // doubles as the PC
	input logic [dataWidth-1:0] icacheRdata,
	output logic [dataWidth-1:0] instr,
	output logic [dataWidth-1:0] pcPlus4
);

	logic [dataWidth-1:0] pcByte;

	assign pcByte = {icacheAddr, 2'b00};

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			icacheRen <= 1'b0;
			icacheAddr <= resetPc[dataWidth-1:2];
			instr <= nopWord;
			pcPlus4 <= '0;
		end else begin
			icacheRen <= 1'b1;
			if (!freeze && !hazard) begin
				if (branchTaken) begin
					icacheAddr <= branchTarget[dataWidth-1:2];
					instr <= nopWord; // squash the slot behind beq
				end else begin
					icacheAddr <= icacheAddr + 1'b1;
					instr <= icacheRdata;
					pcPlus4 <= pcByte + 32'd4;
				end
			end
		end
	end

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import isaPkg::*, pipePkg::*; (
	input logic [dataWidth-1:0] instr,
	input logic [dataWidth-1:0] pcPlus4,
	output regIdx rsAddr,
	output regIdx rtAddr,
	input logic [dataWidth-1:0] rsData,
	input logic [dataWidth-1:0] rtData,
	input regIdx exRd,
	input logic exMemRead,
	input regIdx memRd,
	output logic hazard,
	output logic branchTaken,
	output logic [dataWidth-1:0] branchTarget,
	output idExPayload idEx
);

	logic [opWidth-1:0] opcode;
	logic [fnWidth-1:0] funct;
	logic [immWidth-1:0] immField;
	regIdx rdField;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic useImm;
	logic signExt;
	logic usesRt;
	logic writesRd;
	logic isBeq;
	aluOp op;
	logic [dataWidth-1:0] immExt;
	logic loadUse;
	logic branchWait;

	function automatic logic hits(input regIdx dst, input regIdx src);
		return (dst != '0) && (dst == src);
	endfunction

	assign opcode = instr[opLsb +: opWidth];
	assign rsAddr = instr[rsLsb +: regIdxWidth];
	assign rtAddr = instr[rtLsb +: regIdxWidth];
	assign rdField = instr[rdLsb +: regIdxWidth];
	assign funct = instr[fnLsb +: fnWidth];
	assign immField = instr[immLsb +: immWidth];

	always_comb begin
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		useImm = 1'b0;
		signExt = 1'b0;
		usesRt = 1'b0;
		writesRd = 1'b0;
		isBeq = 1'b0;
		op = aluAdd;
		case (opcode)
			opRtype: begin
				regWrite = 1'b1;
				usesRt = 1'b1;
				writesRd = 1'b1;
				case (funct)
					fnAdd: op = aluAdd;
					fnSub: op = aluSub;
					fnAnd: op = aluAnd;
					fnOr: op = aluOr;
					fnXor: op = aluXor;
					fnNor: op = aluNor;
					fnSlt: op = aluSlt;
					default: regWrite = 1'b0; // nop and unsupported funct
				endcase
			end
			opLw: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				useImm = 1'b1;
				signExt = 1'b1;
			end
			opSw: begin
				memWrite = 1'b1;
				useImm = 1'b1;
				signExt = 1'b1;
				usesRt = 1'b1; // store data
			end
			opBeq: begin
				isBeq = 1'b1;
				usesRt = 1'b1;
				signExt = 1'b1;
			end
			opAddi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				signExt = 1'b1;
			end
			opSlti: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				signExt = 1'b1;
				op = aluSlt;
			end
			opAndi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				op = aluAnd;
			end
			opOri: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				op = aluOr;
			end
			opXori: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				op = aluXor;
			end
			default: op = aluAdd;
		endcase
	end

	assign immExt = {{(dataWidth-immWidth){signExt & immField[immWidth-1]}}, immField};

	// lw in execute feeding this instruction
	assign loadUse = exMemRead && (hits(exRd, rsAddr) || (usesRt && hits(exRd, rtAddr)));
	// beq compares in decode, so wait for results still in execute or memory
	assign branchWait = isBeq && (hits(exRd, rsAddr) || hits(exRd, rtAddr) ||
		hits(memRd, rsAddr) || hits(memRd, rtAddr));
	assign hazard = loadUse | branchWait;

	assign branchTaken = isBeq && !hazard && (rsData == rtData);
	assign branchTarget = pcPlus4 + {immExt[dataWidth-3:0], 2'b00};

	always_comb begin
		idEx.regWrite = regWrite;
		idEx.memRead = memRead;
		idEx.memWrite = memWrite;
		idEx.useImm = useImm;
		idEx.op = op;
		idEx.rs = rsAddr;
		idEx.rt = usesRt ? rtAddr : '0;
		idEx.rd = !regWrite ? '0 : (writesRd ? rdField : rtAddr);
		idEx.rsVal = rsData;
		idEx.rtVal = rtData;
		idEx.imm = immExt;
	end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/10ps

module regFile import isaPkg::*; (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic freeze,
	input regIdx rsAddr,
	input regIdx rtAddr,
	output logic [dataWidth-1:0] rsData,
	output logic [dataWidth-1:0] rtData,
	input logic wbRegWrite,
	input regIdx wbRd,
	input logic [dataWidth-1:0] wbData
);

	localparam int numRegs = 2 ** regIdxWidth;

	logic [dataWidth-1:0] regs [numRegs];

	// writeback lands in the same cycle the read sees it
	function automatic logic [dataWidth-1:0] readPort(input regIdx addr);
		if (addr == '0)
			return '0;
		else if (wbRegWrite && wbRd == addr)
			return wbData;
		else
			return regs[addr];
	endfunction

	always_comb begin
		rsData = readPort(rsAddr);
		rtData = readPort(rtAddr);
	end

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (!freeze && wbRegWrite && wbRd != '0) begin
			regs[wbRd] <= wbData; // r0 never written
		end
	end

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage import isaPkg::*, pipePkg::*; (
	input idExPayload ex,
	input regIdx memRd,
	input logic memRegWrite,
	input logic [dataWidth-1:0] memWbData,
	input regIdx wbRd,
	input logic wbRegWrite,
	input logic [dataWidth-1:0] wbData,
	output exMemPayload exMem
);

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] rtFwd;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] result;

	// memory stage is newer than writeback, so it wins
	function automatic logic [dataWidth-1:0] forwardSrc(
		input regIdx src,
		input logic [dataWidth-1:0] own
	);
		if (src != '0 && memRegWrite && memRd == src)
			return memWbData;
		else if (src != '0 && wbRegWrite && wbRd == src)
			return wbData;
		else
			return own;
	endfunction

	always_comb begin
		opA = forwardSrc(ex.rs, ex.rsVal);
		rtFwd = forwardSrc(ex.rt, ex.rtVal);
		opB = ex.useImm ? ex.imm : rtFwd;
		case (ex.op)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluXor: result = opA ^ opB;
			aluNor: result = ~(opA | opB);
			aluSlt: result = {{(dataWidth-1){1'b0}}, opA < opB}; // unsigned compare
			default: result = opA + opB;
		endcase
	end

	always_comb begin
		exMem.regWrite = ex.regWrite;
		exMem.memRead = ex.memRead;
		exMem.memWrite = ex.memWrite;
		exMem.rd = ex.rd;
		exMem.aluResult = result; // also the load/store address
		exMem.storeData = rtFwd;
	end

endmodule

//--- verilog/mipsPipeline.sv
`timescale 1ns/10ps

module mipsPipeline import isaPkg::*, pipePkg::*; #(
	parameter logic [dataWidth-1:0] resetPc = '0
) (
	input logic DCACHE_stall, // core clock
	input logic rst_n,
	output logic icacheRen,
	output logic [wordAddrWidth-1:0] icacheAddr,
	input logic [dataWidth-1:0] icacheRdata,
	input logic icacheStall,
	output logic dcacheRen,
	output logic dcacheWen,
	output logic [wordAddrWidth-1:0] dcacheAddr,
	output logic [dataWidth-1:0] dcacheWdata,
	input logic [dataWidth-1:0] dcacheRdata,
	input logic dcacheStall
);

	logic freeze;
	logic hazard;
	logic branchTaken;
	logic [dataWidth-1:0] branchTarget;
	logic [dataWidth-1:0] instr;
	logic [dataWidth-1:0] pcPlus4;
	regIdx rsAddr;
	regIdx rtAddr;
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;
	idExPayload idExD;
	idExPayload idExQ;
	exMemPayload exMemD;
	exMemPayload exMemQ;
	memWbPayload memWbD;
	memWbPayload memWbQ;
	logic [dataWidth-1:0] memWbData;

	assign freeze = icacheStall | dcacheStall; // whole core holds

	fetchStage #(
		.resetPc(resetPc)
	) fetch (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.freeze(freeze),
		.hazard(hazard),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.icacheRen(icacheRen),
		.icacheAddr(icacheAddr),
		.icacheRdata(icacheRdata),
		.instr(instr),
		.pcPlus4(pcPlus4)
	);

	decodeStage decode (
		.instr(instr),
		.pcPlus4(pcPlus4),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.exRd(idExQ.rd),
		.exMemRead(idExQ.memRead),
		.memRd(exMemQ.rd),
		.hazard(hazard),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.idEx(idExD)
	);

	regFile regs (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.freeze(freeze),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.wbRegWrite(memWbQ.regWrite),
		.wbRd(memWbQ.rd),
		.wbData(memWbQ.wbData)
	);

	pipeReg #(.payloadT(idExPayload)) idEx (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.freeze(freeze),
		.bubble(hazard), // interlock bubble
		.d(idExD),
		.q(idExQ)
	);

	executeStage execute (
		.ex(idExQ),
		.memRd(exMemQ.rd),
		.memRegWrite(exMemQ.regWrite),
		.memWbData(memWbData),
		.wbRd(memWbQ.rd),
		.wbRegWrite(memWbQ.regWrite),
		.wbData(memWbQ.wbData),
		.exMem(exMemD)
	);

	pipeReg #(.payloadT(exMemPayload)) exMem (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.freeze(freeze),
		.bubble(1'b0),
		.d(exMemD),
		.q(exMemQ)
	);

	assign dcacheRen = exMemQ.memRead;
	assign dcacheWen = exMemQ.memWrite;
	assign dcacheAddr = exMemQ.aluResult[dataWidth-1:2];
	assign dcacheWdata = exMemQ.storeData;

	assign memWbData = exMemQ.memRead ? dcacheRdata : exMemQ.aluResult;
	assign memWbD = '{regWrite: exMemQ.regWrite, rd: exMemQ.rd, wbData: memWbData};

	pipeReg #(.payloadT(memWbPayload)) memWb (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.freeze(freeze),
		.bubble(1'b0),
		.d(memWbD),
		.q(memWbQ)
	);

endmodule

//--- sim/tbMipsPipeline.sv
`timescale 1ns/10ps

module tbMipsPipeline import isaPkg::*; ;

	localparam logic [31:0] resetPc = 32'h0000_0040;
	localparam int baseWord = resetPc >> 2;
	localparam int doneAddr = baseWord + 16; // past the last slot plus pipeline depth
	localparam int numRows = 4;
	localparam int numPasses = 2; // without and with cache stalls
	localparam int maxWords = 12;
	localparam int maxStores = 6;
	localparam int cycleLimit = numRows * numPasses * 200;

	logic DCACHE_stall;
	logic rst_n;
	logic icacheRen;
	logic [wordAddrWidth-1:0] icacheAddr;
	logic [dataWidth-1:0] icacheRdata;
	logic icacheStall;
	logic dcacheRen;
	logic dcacheWen;
	logic [wordAddrWidth-1:0] dcacheAddr;
	logic [dataWidth-1:0] dcacheWdata;
	logic [dataWidth-1:0] dcacheRdata;
	logic dcacheStall;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] progTab [numRows][maxWords];
	logic [31:0] stAddrTab [numRows][maxStores];
	logic [31:0] stDataTab [numRows][maxStores];
	int storeCnt [numRows];

	int curRow;
	int storeIdx;
	int failures;
	int cycleCount;
	int iLeft;
	int dLeft;
	logic running;
	logic stallsOn;
	logic advanced;
	logic [31:0] rngState;
	logic [31:0] draw;

	mipsPipeline #(
		.resetPc(resetPc)
	) UUT (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.icacheRen(icacheRen),
		.icacheAddr(icacheAddr),
		.icacheRdata(icacheRdata),
		.icacheStall(icacheStall),
		.dcacheRen(dcacheRen),
		.dcacheWen(dcacheWen),
		.dcacheAddr(dcacheAddr),
		.dcacheWdata(dcacheWdata),
		.dcacheRdata(dcacheRdata),
		.dcacheStall(dcacheStall)
	);

	assign icacheRdata = imem[icacheAddr[5:0]];
	assign dcacheRdata = dcacheRen ? dmem[dcacheAddr[5:0]] : 'x; // data only on a read

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rInstr(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] sx16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [31:0] zx16(input logic [15:0] v);
		return {16'h0000, v};
	endfunction

	function automatic logic [31:0] fillWord(input int i);
		return 32'h1357_0000 ^ (i * 32'h0101_0101);
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			failures++;
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic stopRun(input string why);
		failures++;
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic expectStore(input int row, input logic [31:0] addr, input logic [31:0] data);
		stAddrTab[row][storeCnt[row]] = addr;
		stDataTab[row][storeCnt[row]] = data;
		storeCnt[row]++;
	endtask

	task automatic buildTable();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		for (int r = 0; r < numRows; r++) begin
			storeCnt[r] = 0;
			for (int k = 0; k < maxWords; k++)
				progTab[r][k] = nopWord;
		end
		// immediates with their own extension
		progTab[0][0] = iInstr(opAddi, 1, 0, 16'hF0F0);
		progTab[0][1] = iInstr(opOri, 2, 0, 16'h8001);
		progTab[0][2] = iInstr(opXori, 3, 1, 16'h8F0F);
		progTab[0][3] = iInstr(opAndi, 4, 1, 16'hFF0F);
		progTab[0][4] = iInstr(opSlti, 5, 2, 16'h8000);
		progTab[0][5] = iInstr(opSlti, 6, 1, 16'h0005);
		for (int k = 0; k < 6; k++)
			progTab[0][6 + k] = iInstr(opSw, 5'(k + 1), 0, 16'(4 * k));
		expectStore(0, 0, sx16(16'hF0F0));
		expectStore(0, 1, zx16(16'h8001));
		expectStore(0, 2, sx16(16'hF0F0) ^ zx16(16'h8F0F));
		expectStore(0, 3, sx16(16'hF0F0) & zx16(16'hFF0F));
		expectStore(0, 4, (zx16(16'h8001) < sx16(16'h8000)) ? 32'd1 : 32'd0);
		expectStore(0, 5, (sx16(16'hF0F0) < sx16(16'h0005)) ? 32'd1 : 32'd0);
		// dependent R-type chain
		progTab[1][0] = iInstr(opAddi, 1, 0, 16'd100);
		progTab[1][1] = iInstr(opAddi, 2, 0, 16'd7);
		progTab[1][2] = rInstr(fnAdd, 3, 1, 2);
		progTab[1][3] = rInstr(fnSub, 3, 3, 2);
		progTab[1][4] = rInstr(fnOr, 3, 3, 2);
		progTab[1][5] = rInstr(fnXor, 3, 3, 1);
		progTab[1][6] = rInstr(fnNor, 3, 3, 2);
		progTab[1][7] = rInstr(fnAnd, 4, 3, 1);
		progTab[1][8] = rInstr(fnSlt, 5, 2, 3);
		progTab[1][9] = iInstr(opSw, 3, 0, 16'd0);
		progTab[1][10] = iInstr(opSw, 4, 0, 16'd4);
		progTab[1][11] = iInstr(opSw, 5, 0, 16'd8);
		a = 32'd100;
		b = 32'd7;
		c = ~((((a + b) - b) | b) ^ a | b);
		expectStore(1, 0, c);
		expectStore(1, 1, c & a);
		expectStore(1, 2, (b < c) ? 32'd1 : 32'd0); // unsigned compare
		// load-use interlocks
		progTab[2][0] = iInstr(opAddi, 1, 0, 16'd40);
		progTab[2][1] = iInstr(opAddi, 4, 0, 16'h0123);
		progTab[2][2] = iInstr(opLw, 2, 1, 16'd8);
		progTab[2][3] = rInstr(fnAdd, 3, 2, 4);
		progTab[2][4] = iInstr(opSw, 3, 1, 16'd0);
		progTab[2][5] = iInstr(opLw, 5, 1, 16'd0);
		progTab[2][6] = rInstr(fnAdd, 6, 4, 5);
		progTab[2][7] = iInstr(opSw, 6, 1, 16'd4);
		progTab[2][8] = iInstr(opLw, 7, 1, 16'hFFFC);
		progTab[2][9] = iInstr(opSw, 7, 0, 16'd8);
		expectStore(2, 10, fillWord(12) + 32'h0123);
		expectStore(2, 11, fillWord(12) + 32'h0246);
		expectStore(2, 2, fillWord(9));
		// beq right behind writes of its sources
		progTab[3][0] = iInstr(opAddi, 1, 0, 16'd5);
		progTab[3][1] = iInstr(opBeq, 0, 1, 16'd2); // not taken
		progTab[3][2] = iInstr(opSw, 1, 0, 16'd0);
		progTab[3][3] = iInstr(opAddi, 2, 0, 16'd5);
		progTab[3][4] = iInstr(opBeq, 2, 1, 16'd2); // taken to slot 7
		progTab[3][5] = iInstr(opSw, 1, 0, 16'd4);
		progTab[3][6] = iInstr(opSw, 1, 0, 16'd8);
		progTab[3][7] = iInstr(opSw, 2, 0, 16'd12);
		progTab[3][8] = iInstr(opLw, 3, 0, 16'd12);
		progTab[3][9] = iInstr(opBeq, 2, 3, 16'd1); // taken to slot 11
		progTab[3][10] = iInstr(opSw, 0, 0, 16'd16);
		progTab[3][11] = iInstr(opSw, 3, 0, 16'd20);
		expectStore(3, 0, 32'd5);
		expectStore(3, 3, 32'd5);
		expectStore(3, 5, 32'd5);
	endtask

	task automatic loadRow(input int row);
		for (int i = 0; i < 64; i++) begin
			imem[i] = nopWord;
			dmem[i] = fillWord(i);
		end
		for (int k = 0; k < maxWords; k++)
			imem[baseWord + k] = progTab[row][k];
	endtask

	initial begin
		DCACHE_stall = 1'b0;
		forever #5 DCACHE_stall = ~DCACHE_stall;
	end

	always @(posedge DCACHE_stall) begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
			stopRun("timeout: a program did not run to its end within the cycle limit");
	end

	// cache stall models, driven just after the edge
	always begin
		@(posedge DCACHE_stall);
		#1;
		if (!stallsOn) begin
			icacheStall = 1'b0;
			dcacheStall = 1'b0;
			iLeft = 0;
			dLeft = 0;
		end else begin
			if (iLeft != 0) begin
				iLeft--;
			end else if (icacheStall) begin
				icacheStall = 1'b0; // let one fetch through
			end else begin
				rngState = xorshift(rngState);
				draw = rngState % 4;
				icacheStall = (draw != 0);
				iLeft = (draw == 0) ? 0 : int'(draw) - 1;
			end
			if (!(dcacheRen || dcacheWen)) begin
				dcacheStall = 1'b0;
				dLeft = 0;
			end else if (advanced) begin
				rngState = xorshift(rngState); // new access
				draw = rngState % 4;
				dcacheStall = (draw != 0);
				dLeft = (draw == 0) ? 0 : int'(draw) - 1;
			end else if (dLeft != 0) begin
				dLeft--;
			end else begin
				dcacheStall = 1'b0;
			end
		end
	end

	// store monitor, mid-cycle
	always @(negedge DCACHE_stall) begin
		advanced = !icacheStall && !dcacheStall;
		if (running && dcacheWen && advanced) begin
			if (storeIdx >= storeCnt[curRow]) begin
				stopRun("a store happened beyond the expected sequence");
			end else begin
				checkEq("dcacheAddr", {2'b00, dcacheAddr}, stAddrTab[curRow][storeIdx]);
				checkEq("dcacheWdata", dcacheWdata, stDataTab[curRow][storeIdx]);
				dmem[dcacheAddr[5:0]] = dcacheWdata;
				storeIdx++;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		icacheStall = 1'b0;
		dcacheStall = 1'b0;
		iLeft = 0;
		dLeft = 0;
		running = 1'b0;
		stallsOn = 1'b0;
		advanced = 1'b1;
		rngState = 32'd53;
		failures = 0;
		cycleCount = 0;
		storeIdx = 0;
		curRow = 0;
		buildTable();
		loadRow(0);
		for (int pass = 0; pass < numPasses; pass++) begin
			for (int r = 0; r < numRows; r++) begin
				@(negedge DCACHE_stall);
				stallsOn = (pass == 1);
				curRow = r;
				@(posedge DCACHE_stall);
				#1;
				rst_n = 1'b0;
				loadRow(r);
				repeat (9) @(posedge DCACHE_stall);
				@(negedge DCACHE_stall);
				checkEq("icacheRen", icacheRen, 0);
				checkEq("dcacheRen", dcacheRen, 0);
				checkEq("dcacheWen", dcacheWen, 0);
				checkEq("icacheAddr", {2'b00, icacheAddr}, resetPc >> 2);
				@(posedge DCACHE_stall);
				#1;
				storeIdx = 0;
				running = 1'b1;
				rst_n = 1'b1;
				@(posedge DCACHE_stall);
				@(negedge DCACHE_stall);
				checkEq("icacheRen", icacheRen, 1); // on from the first clock
				while (icacheAddr != doneAddr)
					@(negedge DCACHE_stall);
				checkEq("icacheRen", icacheRen, 1);
				@(posedge DCACHE_stall);
				#1;
				running = 1'b0;
				checkEq("store count", storeIdx, storeCnt[r]);
			end
		end
		if (failures == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- sim.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeReg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/mipsPipeline.sv
sim/tbMipsPipeline.sv
